// File: hdl/rp_io_pkg.sv
`default_nettype none

package rp_io_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADC_IN_W   = 16;                   // Raw ADC pin word
  localparam int SMP_W      = 14;                   // Converter sample
  localparam int CH_W       = 16;                   // DAC channel word
  localparam int BUS_W      = 32;                   // Sys bus addr/data
  localparam int REGION_NUM = 8;                    // Regions on addr[22:20]
  localparam int REGION_W   = $clog2(REGION_NUM);
  localparam int OFS_W      = 20;                   // Offset inside a region
  localparam int REGION_HK  = 0;                    // Housekeeping region

  // Housekeeping map
  localparam logic [BUS_W-1:0] HK_ID     = 32'h5250_0101;  // Board ID word
  localparam logic [OFS_W-1:0] OFS_ID    = 20'h00000;
  localparam logic [OFS_W-1:0] OFS_CTRL  = 20'h00004;      // Bit 0 digital loop
  localparam logic [OFS_W-1:0] OFS_LED   = 20'h00008;
  localparam logic [OFS_W-1:0] OFS_DAC_A = 20'h0000C;
  localparam logic [OFS_W-1:0] OFS_DAC_B = 20'h00010;
  localparam logic [OFS_W-1:0] OFS_ADC_A = 20'h00014;      // Read only
  localparam logic [OFS_W-1:0] OFS_ADC_B = 20'h00018;      // Read only

  // Bus address, plain word or region/offset split
  typedef union packed {
    logic [BUS_W-1:0] raw;
    struct packed {
      logic [BUS_W-REGION_W-OFS_W-1:0] unused;   // Top 9 bits, not decoded
      logic [REGION_W-1:0]             region;   // Bits 22..20
      logic [OFS_W-1:0]                offset;   // Register offset
    } f;
  } sys_addr_u;

endpackage

`default_nettype wire

// File: hdl/rp_sys_bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rp_sys_bus_decoder import rp_io_pkg::*; (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  sys_addr_u        sys_addr_i,
  input  logic             sys_wen_i,
  input  logic             sys_ren_i,
  output logic [BUS_W-1:0] sys_rdata_o,
  output logic             sys_ack_o,
  output logic             sys_err_o,
  output logic             hk_wen_o,     // Region 0 strobes
  output logic             hk_ren_o,
  input  logic [BUS_W-1:0] hk_rdata_i,
  input  logic             hk_ack_i,
  input  logic             hk_err_i
);

  localparam logic [REGION_NUM-1:0] HK_MASK = REGION_NUM'(1) << REGION_HK;

  logic [REGION_NUM-1:0] rgn_sel;       // One-hot region select
  logic                  strobe;
  logic                  stub_hit;      // Strobe lands in an unused region
  logic                  stub_ack;
  logic [REGION_W-1:0]   pend_region;   // Region of the open request
  logic                  pend_is_hk;

  assign rgn_sel  = REGION_NUM'(1) << sys_addr_i.f.region;
  assign strobe   = sys_wen_i | sys_ren_i;
  assign stub_hit = |(rgn_sel & ~HK_MASK);

  // Strobe steering
  assign hk_wen_o = sys_wen_i & |(rgn_sel & HK_MASK);
  assign hk_ren_o = sys_ren_i & |(rgn_sel & HK_MASK);

  //////////////////////////////////////////////////////////////////////
  // Request tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pend_region <= '0;
      stub_ack    <= 1'b0;
    end
    else
    begin
      if (strobe)
        pend_region <= sys_addr_i.f.region;   // Held until next strobe
      stub_ack <= strobe & stub_hit;          // Unused regions answer here
    end
  end

  // Answer return, routed by the stored region
  assign pend_is_hk  = (pend_region == REGION_W'(REGION_HK));
  assign sys_ack_o   = pend_is_hk ? hk_ack_i : stub_ack;
  assign sys_rdata_o = pend_is_hk ? hk_rdata_i : '0;    // Stand-in reads zero
  assign sys_err_o   = pend_is_hk & hk_err_i;           // Never an error

endmodule

`default_nettype wire

// File: hdl/rp_housekeeping.sv
`timescale 1ns/1ps
`default_nettype none

module rp_housekeeping import rp_io_pkg::*; #(
  parameter int LED_W = 8
) (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  sys_addr_u               sys_addr_i,
  input  logic [BUS_W-1:0]        sys_wdata_i,
  input  logic                    hk_wen_i,
  input  logic                    hk_ren_i,
  output logic [BUS_W-1:0]        hk_rdata_o,
  output logic                    hk_ack_o,
  output logic                    hk_err_o,
  output logic [LED_W-1:0]        led_o,
  output logic                    digital_loop_o,
  output logic signed [CH_W-1:0]  dac_a_o,
  output logic signed [CH_W-1:0]  dac_b_o,
  input  logic signed [SMP_W-1:0] adc_a_i,
  input  logic signed [SMP_W-1:0] adc_b_i
);

  logic [OFS_W-1:0] ofs;
  logic [BUS_W-1:0] rd_word;       // Read mux result
  logic             ofs_hit;       // Offset is in the map

  assign ofs = sys_addr_i.f.offset;

  //////////////////////////////////////////////////////////////////////
  // Read decode
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    rd_word = '0;
    ofs_hit = 1'b1;
    case (ofs)
      OFS_ID:    rd_word = HK_ID;
      OFS_CTRL:  rd_word = {{(BUS_W-1){1'b0}}, digital_loop_o};
      OFS_LED:   rd_word = {{(BUS_W-LED_W){1'b0}}, led_o};
      OFS_DAC_A: rd_word = {{(BUS_W-CH_W){1'b0}}, dac_a_o};
      OFS_DAC_B: rd_word = {{(BUS_W-CH_W){1'b0}}, dac_b_o};
      // Samples come back sign extended
      OFS_ADC_A: rd_word = {{(BUS_W-SMP_W){adc_a_i[SMP_W-1]}}, adc_a_i};
      OFS_ADC_B: rd_word = {{(BUS_W-SMP_W){adc_b_i[SMP_W-1]}}, adc_b_i};
      default:   ofs_hit = 1'b0;   // Hole in the map reads zero
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Writable registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      dac_a_o        <= '0;
      dac_b_o        <= '0;
    end
    else if (hk_wen_i)
    begin
      case (ofs)
        OFS_CTRL:  digital_loop_o <= sys_wdata_i[0];
        OFS_LED:   led_o          <= sys_wdata_i[LED_W-1:0];
        OFS_DAC_A: dac_a_o        <= sys_wdata_i[CH_W-1:0];
        OFS_DAC_B: dac_b_o        <= sys_wdata_i[CH_W-1:0];
        default:   ;               // ID and ADC words are read only
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus response one cycle after the strobe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      hk_ack_o <= 1'b0;
      hk_err_o <= 1'b0;
    end
    else
    begin
      hk_ack_o <= hk_wen_i | hk_ren_i;
      hk_err_o <= (hk_wen_i | hk_ren_i) & ~ofs_hit;   // Unmapped offset
    end
  end

  // Read word captured with the strobe
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      hk_rdata_o <= '0;
    else if (hk_ren_i)
      hk_rdata_o <= rd_word;
    else if (hk_wen_i)
      hk_rdata_o <= '0;     // Writes return no data
  end

endmodule

`default_nettype wire

// File: hdl/rp_adc_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module rp_adc_frontend import rp_io_pkg::*; (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  logic                    run_i,            // Converters running
  input  logic [ADC_IN_W-1:0]     adc_dat_a_i,
  input  logic [ADC_IN_W-1:0]     adc_dat_b_i,
  input  logic                    digital_loop_i,
  input  logic signed [CH_W-1:0]  dac_a_i,
  input  logic signed [CH_W-1:0]  dac_b_i,
  output logic signed [SMP_W-1:0] adc_a_o,
  output logic signed [SMP_W-1:0] adc_b_o
);

  logic [SMP_W-1:0]        raw_a;    // Pin bits 15..2, low 2 unused
  logic [SMP_W-1:0]        raw_b;
  logic signed [SMP_W-1:0] smp_a;    // Input register stage
  logic signed [SMP_W-1:0] smp_b;

  assign raw_a = adc_dat_a_i[ADC_IN_W-1 -: SMP_W];
  assign raw_b = adc_dat_b_i[ADC_IN_W-1 -: SMP_W];

  // Negative slope to two's complement, cleared sample reads as zero
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      smp_a <= '0;
      smp_b <= '0;
    end
    else
    begin
      smp_a <= run_i ? {raw_a[SMP_W-1], ~raw_a[SMP_W-2:0]} : '0;
      smp_b <= run_i ? {raw_b[SMP_W-1], ~raw_b[SMP_W-2:0]} : '0;
    end
  end

  // Loopback takes the top 14 bits of each DAC word
  assign adc_a_o = digital_loop_i ? dac_a_i[CH_W-1 -: SMP_W] : smp_a;
  assign adc_b_o = digital_loop_i ? dac_b_i[CH_W-1 -: SMP_W] : smp_b;

endmodule

`default_nettype wire

// File: hdl/rp_dac_backend.sv
`timescale 1ns/1ps
`default_nettype none

module rp_dac_backend import rp_io_pkg::*; (
  input  logic                   adc_clk,
  input  logic                   rst_n_i,
  input  logic                   dac_rst_i,     // DAC held in reset
  input  logic signed [CH_W-1:0] dac_a_i,
  input  logic signed [CH_W-1:0] dac_b_i,
  output logic [SMP_W-1:0]       dac_dat_a_o,
  output logic [SMP_W-1:0]       dac_dat_b_o
);

  // Output registers, signed word to inverted offset code
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= '0;
      dac_dat_b_o <= '0;
    end
    else if (dac_rst_i)
    begin
      dac_dat_a_o <= '0;     // Quiet pins during converter reset
      dac_dat_b_o <= '0;
    end
    else
    begin
      dac_dat_a_o <= {dac_a_i[CH_W-1], ~dac_a_i[CH_W-2:CH_W-SMP_W]};  // Drop 2 LSBs
      dac_dat_b_o <= {dac_b_i[CH_W-1], ~dac_b_i[CH_W-2:CH_W-SMP_W]};
    end
  end

endmodule

`default_nettype wire

// File: hdl/rp_reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module rp_reset_sequencer #(
  parameter int LOCK_HOLDOFF = 16     // Cycles in HOLDOFF before run
) (
  input  logic adc_clk,
  input  logic rst_n_i,
  input  logic pll_locked_i,
  output logic run_o,
  output logic dac_rst_o              // Active high, registered
);

  localparam int CNT_W = $clog2(LOCK_HOLDOFF + 1);

  // FSM encoding
  localparam logic [1:0] ST_WAIT_LOCK = 2'd0;
  localparam logic [1:0] ST_HOLDOFF   = 2'd1;
  localparam logic [1:0] ST_RUN       = 2'd2;

  logic [1:0]       state;
  logic [1:0]       state_nxt;
  logic [CNT_W-1:0] cnt;             // Hold-off counter
  logic             cnt_done;

  assign cnt_done = (cnt == CNT_W'(LOCK_HOLDOFF - 1));

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_WAIT_LOCK: if (pll_locked_i) state_nxt = ST_HOLDOFF;
      ST_HOLDOFF:   if (cnt_done)     state_nxt = ST_RUN;
      ST_RUN:       state_nxt = ST_RUN;
      default:      state_nxt = ST_WAIT_LOCK;
    endcase
    if (!pll_locked_i)
      state_nxt = ST_WAIT_LOCK;      // Lock lost, start over
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state     <= ST_WAIT_LOCK;
      cnt       <= '0;
      dac_rst_o <= 1'b1;             // Converters held after reset
    end
    else
    begin
      state     <= state_nxt;
      cnt       <= (state == ST_HOLDOFF) ? cnt + 1'b1 : '0;
      dac_rst_o <= (state_nxt != ST_RUN);   // Tracks run_o, no extra delay
    end
  end

  assign run_o = (state == ST_RUN);

endmodule

`default_nettype wire

// File: hdl/rp_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module rp_io_top import rp_io_pkg::*; #(
  parameter int LOCK_HOLDOFF = 16,   // Cycles from lock to run
  parameter int LED_W        = 8
) (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  input  logic                pll_locked_i,     // Clock source lock
  // ADC pins
  input  logic [ADC_IN_W-1:0] adc_dat_a_i,
  input  logic [ADC_IN_W-1:0] adc_dat_b_i,
  // System bus
  input  sys_addr_u           sys_addr_i,
  input  logic [BUS_W-1:0]    sys_wdata_i,
  input  logic                sys_wen_i,
  input  logic                sys_ren_i,
  output logic [BUS_W-1:0]    sys_rdata_o,
  output logic                sys_ack_o,
  output logic                sys_err_o,
  // DAC pins, one port per channel
  output logic [SMP_W-1:0]    dac_dat_a_o,
  output logic [SMP_W-1:0]    dac_dat_b_o,
  output logic                dac_rst_o,
  output logic [LED_W-1:0]    led_o
);

  //////////////////////////////////////////////////////////////////////
  // Local wires
  //////////////////////////////////////////////////////////////////////

  // Region 0 bus slice
  logic                    hk_wen;
  logic                    hk_ren;
  logic [BUS_W-1:0]        hk_rdata;
  logic                    hk_ack;
  logic                    hk_err;

  logic                    digital_loop;    // ADC readback from DAC words
  logic signed [CH_W-1:0]  dac_a;
  logic signed [CH_W-1:0]  dac_b;
  logic signed [SMP_W-1:0] adc_a;
  logic signed [SMP_W-1:0] adc_b;
  logic                    run;             // Converters out of reset

  //////////////////////////////////////////////////////////////////////
  // Bus decoder and housekeeping
  //////////////////////////////////////////////////////////////////////

  rp_sys_bus_decoder i_dec (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .hk_err_i    (hk_err)
  );

  rp_housekeeping #(
    .LED_W (LED_W)
  ) i_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .sys_addr_i     (sys_addr_i),        // Shared address, offset view
    .sys_wdata_i    (sys_wdata_i),
    .hk_wen_i       (hk_wen),
    .hk_ren_i       (hk_ren),
    .hk_rdata_o     (hk_rdata),
    .hk_ack_o       (hk_ack),
    .hk_err_o       (hk_err),
    .led_o          (led_o),
    .digital_loop_o (digital_loop),
    .dac_a_o        (dac_a),
    .dac_b_o        (dac_b),
    .adc_a_i        (adc_a),
    .adc_b_i        (adc_b)
  );

  //////////////////////////////////////////////////////////////////////
  // Converter paths and reset sequencing
  //////////////////////////////////////////////////////////////////////

  rp_adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .run_i          (run),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_a_i        (dac_a),
    .dac_b_i        (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  rp_dac_backend i_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .dac_rst_i   (dac_rst_o),           // Same reset the DAC chip sees
    .dac_a_i     (dac_a),
    .dac_b_i     (dac_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

  rp_reset_sequencer #(
    .LOCK_HOLDOFF (LOCK_HOLDOFF)
  ) i_rst_seq (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .pll_locked_i (pll_locked_i),
    .run_o        (run),
    .dac_rst_o    (dac_rst_o)
  );

endmodule

`default_nettype wire

// File: dv/tb_rp_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rp_io_top import rp_io_pkg::*; ();

  localparam int LED_W        = 8;
  localparam int LOCK_HOLDOFF = 16;
  localparam int BUS_TIMEOUT  = 8;                   // Cycles allowed for an ack
  localparam int LOCK_TIMEOUT = LOCK_HOLDOFF + 16;   // Lock to run, with margin

  logic             adc_clk;
  logic             rst_n_i;
  logic             pll_locked;
  logic [15:0]      adc_a_pin;
  logic [15:0]      adc_b_pin;
  sys_addr_u        sys_addr;
  logic [31:0]      sys_wdata;
  logic             sys_wen;
  logic             sys_ren;
  logic [31:0]      sys_rdata;
  logic             sys_ack;
  logic             sys_err;
  logic [13:0]      dac_dat_a;
  logic [13:0]      dac_dat_b;
  logic             dac_rst;
  logic [LED_W-1:0] led;

  // Register model
  logic             m_loop;
  logic [LED_W-1:0] m_led;
  logic [15:0]      m_dac_a;
  logic [15:0]      m_dac_b;
  logic [15:0]      lfsr;          // Random source state

  rp_io_top #(
    .LOCK_HOLDOFF (LOCK_HOLDOFF),
    .LED_W        (LED_W)
  ) dut0 (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .pll_locked_i (pll_locked),
    .adc_dat_a_i  (adc_a_pin),
    .adc_dat_b_i  (adc_b_pin),
    .sys_addr_i   (sys_addr),
    .sys_wdata_i  (sys_wdata),
    .sys_wen_i    (sys_wen),
    .sys_ren_i    (sys_ren),
    .sys_rdata_o  (sys_rdata),
    .sys_ack_o    (sys_ack),
    .sys_err_o    (sys_err),
    .dac_dat_a_o  (dac_dat_a),
    .dac_dat_b_o  (dac_dat_b),
    .dac_rst_o    (dac_rst),
    .led_o        (led)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;   // 4 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // Random numbers and expected values
  //////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);      // One step per bit
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Pin bits 15..2, inverted slope to two's complement, sign extended
  function automatic logic [31:0] adc_expect(input logic [15:0] pin);
    logic [13:0] conv;
    conv = {pin[15], ~pin[14:2]};
    return {{18{conv[13]}}, conv};
  endfunction

  function automatic logic [31:0] loop_expect(input logic [15:0] w);
    return {{18{w[15]}}, w[15:2]};   // Top 14 bits of the channel word
  endfunction

  function automatic logic [13:0] dac_expect(input logic [15:0] w);
    return {w[15], ~w[14:2]};        // Inverted offset code
  endfunction

  function automatic logic [31:0] hk_addr(input logic [19:0] ofs);
    return {9'h0, 3'd0, ofs};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks and bus access
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge adc_clk);
      #1;
    end
  endtask

  // Strobe for one cycle, return at the acknowledge
  task automatic bus_request(input logic is_wr, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
    int waited;
    sys_addr.raw = addr;
    sys_wdata    = wdata;
    sys_wen      = is_wr;
    sys_ren      = !is_wr;
    idle_cycles(1);
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    waited  = 0;
    while (sys_ack !== 1'b1)
    begin
      if (waited >= BUS_TIMEOUT)
      begin
        $display("timeout: no bus acknowledge for address 0x%08h", addr);
        abort_run();
      end
      idle_cycles(1);
      waited++;
    end
    check_value("sys_ack_o latency", 32'(waited), 32'd0);   // Next cycle only
    rdata = sys_rdata;
    err   = sys_err;
  endtask

  task automatic finish_request();
    idle_cycles(1);
    check_value("sys_ack_o", 32'(sys_ack), 32'd0);        // Single cycle ack
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    bus_request(1'b1, addr, wdata, rdata, err);
    check_value("sys_err_o", 32'(err), 32'(exp_err));
    finish_request();
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp_data,
                          input logic exp_err, input string name);
    logic [31:0] rdata;
    logic        err;
    bus_request(1'b0, addr, 32'h0, rdata, err);
    check_value(name, rdata, exp_data);
    check_value("sys_err_o", 32'(err), 32'(exp_err));
    finish_request();
  endtask

  task automatic wait_dac_rst(input logic level, input string what);
    int waited;
    waited = 0;
    while (dac_rst !== level)
    begin
      if (waited >= LOCK_TIMEOUT)
      begin
        $display("timeout waiting for %s", what);
        abort_run();
      end
      idle_cycles(1);
      waited++;
    end
  endtask

  task automatic check_dac_pins();
    check_value("dac_dat_a_o", 32'(dac_dat_a), 32'(dac_expect(m_dac_a)));
    check_value("dac_dat_b_o", 32'(dac_dat_b), 32'(dac_expect(m_dac_b)));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Scenarios
  //////////////////////////////////////////////////////////////////////

  task automatic reset_sequencing();
    adc_a_pin = 16'(rand_bits(16));
    adc_b_pin = 16'(rand_bits(16));
    check_value("sys_ack_o", 32'(sys_ack), 32'd0);
    check_value("sys_err_o", 32'(sys_err), 32'd0);
    check_value("led_o", 32'(led), 32'd0);
    check_value("dac_dat_a_o", 32'(dac_dat_a), 32'd0);
    check_value("dac_dat_b_o", 32'(dac_dat_b), 32'd0);
    repeat (20)
    begin
      check_value("dac_rst_o", 32'(dac_rst), 32'd1);   // No lock yet
      idle_cycles(1);
    end
    pll_locked = 1'b1;
    wait_dac_rst(1'b0, "dac_rst_o to fall after lock");
    idle_cycles(3);
    bus_read(hk_addr(OFS_ADC_A), adc_expect(adc_a_pin), 1'b0, "sys_rdata_o adc_a");
    pll_locked = 1'b0;
    idle_cycles(1);
    check_value("dac_rst_o", 32'(dac_rst), 32'd1);     // Lock lost
    idle_cycles(2);
    bus_read(hk_addr(OFS_ADC_A), 32'h0, 1'b0, "sys_rdata_o adc_a");
    bus_read(hk_addr(OFS_ADC_B), 32'h0, 1'b0, "sys_rdata_o adc_b");
    pll_locked = 1'b1;
    wait_dac_rst(1'b0, "dac_rst_o to fall after relock");
  endtask

  task automatic id_and_error_answers();
    logic [19:0] ofs;
    logic [2:0]  rgn;
    int          i;
    bus_read(hk_addr(OFS_ID), HK_ID, 1'b0, "sys_rdata_o id");
    bus_write(hk_addr(OFS_ID), rand_bits(32), 1'b0);   // Ignored, no error
    bus_read(hk_addr(OFS_ID), HK_ID, 1'b0, "sys_rdata_o id");
    for (i = 0; i < 8; i++)
    begin
      ofs = 20'(rand_bits(20)) | 20'h1;                // Odd offsets are holes
      if (i[0])
        bus_write({9'(rand_bits(9)), 3'd0, ofs}, rand_bits(32), 1'b1);
      else
        bus_read({9'(rand_bits(9)), 3'd0, ofs}, 32'h0, 1'b1, "sys_rdata_o hole");
    end
    for (i = 0; i < 12; i++)
    begin
      rgn = 3'(rand_bits(3));
      if (rgn == 3'd0)
        rgn = 3'd1;
      ofs = 20'(rand_bits(20));
      if (i[0])
        bus_write({9'(rand_bits(9)), rgn, ofs}, rand_bits(32), 1'b0);
      else
        bus_read({9'(rand_bits(9)), rgn, ofs}, 32'h0, 1'b0, "sys_rdata_o region");
    end
  endtask

  task automatic led_and_ctrl_access();
    logic [31:0] wdata;
    repeat (6)
    begin
      wdata = rand_bits(32);
      bus_write(hk_addr(OFS_LED), wdata, 1'b0);
      m_led = wdata[LED_W-1:0];
      check_value("led_o", 32'(led), 32'(m_led));
      bus_read(hk_addr(OFS_LED), 32'(m_led), 1'b0, "sys_rdata_o led");
      wdata = rand_bits(32);
      bus_write(hk_addr(OFS_CTRL), wdata, 1'b0);
      m_loop = wdata[0];
      bus_read(hk_addr(OFS_CTRL), 32'(m_loop), 1'b0, "sys_rdata_o ctrl");
    end
  endtask

  task automatic dac_output_path();
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
    int          i;
    for (i = 0; i < 10; i++)
    begin
      wdata = rand_bits(32);
      bus_request(1'b1, hk_addr(i[0] ? OFS_DAC_B : OFS_DAC_A), wdata, rdata, err);
      check_value("sys_err_o", 32'(err), 32'd0);
      check_dac_pins();                                // Old code at the ack
      finish_request();
      if (i[0])
        m_dac_b = wdata[15:0];
      else
        m_dac_a = wdata[15:0];
      check_dac_pins();                                // New code a cycle later
      bus_read(hk_addr(i[0] ? OFS_DAC_B : OFS_DAC_A), 32'(wdata[15:0]), 1'b0,
               "sys_rdata_o dac");
    end
  endtask

  task automatic adc_readback_path();
    logic [31:0] wdata;
    bus_write(hk_addr(OFS_CTRL), 32'h0, 1'b0);
    m_loop = 1'b0;
    repeat (8)
    begin
      adc_a_pin = 16'(rand_bits(16));
      adc_b_pin = 16'(rand_bits(16));
      idle_cycles(3);                                  // Inputs held steady
      bus_read(hk_addr(OFS_ADC_A), adc_expect(adc_a_pin), 1'b0, "sys_rdata_o adc_a");
      bus_read(hk_addr(OFS_ADC_B), adc_expect(adc_b_pin), 1'b0, "sys_rdata_o adc_b");
    end
    bus_write(hk_addr(OFS_CTRL), 32'h1, 1'b0);
    m_loop = 1'b1;
    repeat (6)
    begin
      wdata = rand_bits(32);
      bus_write(hk_addr(OFS_DAC_A), wdata, 1'b0);
      m_dac_a = wdata[15:0];
      wdata = rand_bits(32);
      bus_write(hk_addr(OFS_DAC_B), wdata, 1'b0);
      m_dac_b = wdata[15:0];
      bus_read(hk_addr(OFS_ADC_A), loop_expect(m_dac_a), 1'b0, "sys_rdata_o adc_a");
      bus_read(hk_addr(OFS_ADC_B), loop_expect(m_dac_b), 1'b0, "sys_rdata_o adc_b");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    rst_n_i      = 1'b0;
    pll_locked   = 1'b0;
    adc_a_pin    = '0;
    adc_b_pin    = '0;
    sys_addr.raw = '0;
    sys_wdata    = '0;
    sys_wen      = 1'b0;
    sys_ren      = 1'b0;
    m_loop       = 1'b0;
    m_led        = '0;
    m_dac_a      = '0;
    m_dac_b      = '0;
    lfsr         = 16'd78;                             // Fixed seed
    repeat (2) @(posedge adc_clk);
    #1;
    rst_n_i = 1'b1;
    reset_sequencing();
    id_and_error_answers();
    led_and_ctrl_access();
    dac_output_path();
    adc_readback_path();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: rp_io_top.f
hdl/rp_io_pkg.sv
hdl/rp_sys_bus_decoder.sv
hdl/rp_housekeeping.sv
hdl/rp_adc_frontend.sv
hdl/rp_dac_backend.sv
hdl/rp_reset_sequencer.sv
hdl/rp_io_top.sv
dv/tb_rp_io_top.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f rp_io_top.f --top-module tb_rp_io_top -Mdir obj_dir

# Pass or fail comes from the log, not the exit status
run: compile
	./obj_dir/Vtb_rp_io_top | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log
